// File: hdl/mem_stage_pkg.sv
package mem_stage_pkg;

  // ====================================================================
  // Widths
  // ====================================================================

  // Data and address width
  localparam int XLEN       = 32;
  // Byte lanes in one data word
  localparam int NUM_LANES  = 4;
  // Bits that pick a lane inside a word
  localparam int LANE_IDX_W = $clog2(NUM_LANES);
  // Register file index
  localparam int REG_ADDR_W = 5;
  // Sub-word sizes used by the load aligner
  localparam int BYTE_W     = 8;
  localparam int HALF_W     = 16;

  // ====================================================================
  // Encodings
  // ====================================================================

  // Load/store width, same layout as funct3
  // Low two bits give the size, bit 2 marks an unsigned load
  typedef enum logic [2:0] {
    LS_B  = 3'd0,
    LS_H  = 3'd1,
    LS_W  = 3'd2,
    LS_BU = 3'd4,
    LS_HU = 3'd5
  } ls_size_e;

  // Source of the value written back to rd
  typedef enum logic [2:0] {
    RES_ALU = 3'd0,
    RES_MEM = 3'd1,
    RES_PC4 = 3'd2,
    RES_TGT = 3'd3,
    RES_CSR = 3'd4
  } res_src_e;

  // Trap cause carried down the pipe
  typedef enum logic [1:0] {
    TRAP_NONE          = 2'd0,
    TRAP_ILLEGAL       = 2'd1,
    TRAP_ECALL         = 2'd2,
    TRAP_LDST_MISALIGN = 2'd3
  } trap_code_e;

  // ====================================================================
  // Stage bundles
  // ====================================================================

  // Handed over by the execute stage
  typedef struct packed {
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    res_src_e              res_src;
    logic [REG_ADDR_W-1:0] rd;
    ls_size_e              size;
    logic [XLEN-1:0]       alu_result;  // Effective address for loads and stores
    logic [XLEN-1:0]       rs2_data;    // Raw store data
    logic [XLEN-1:0]       pc_plus4;
    logic [XLEN-1:0]       jb_tgt;
    logic [XLEN-1:0]       csr_rdata;
    logic                  trap;
    trap_code_e            trap_code;
  } ex_mem_t;

  // Request toward the data memory, addresses always word aligned
  typedef struct packed {
    logic                 ren;
    logic [XLEN-1:0]      raddr;
    logic                 we;
    logic [XLEN-1:0]      waddr;
    logic [XLEN-1:0]      wdata;
    logic [NUM_LANES-1:0] wstrb;
  } dmem_req_t;

  // Contents of the MEM/WB register
  typedef struct packed {
    logic                  reg_write;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       wb_data;
    logic                  trap;
    trap_code_e            trap_code;
  } mem_wb_t;

endpackage

// File: hdl/mem_access.sv
`timescale 1ns/10ps

// Address check, store lane formatting and data-memory request
// Purely combinational
module mem_access (
  input  logic                          ex_valid_i,
  input  mem_stage_pkg::ex_mem_t        ex_i,
  output mem_stage_pkg::dmem_req_t      dmem_req_o,
  output logic                          trap_o,
  output mem_stage_pkg::trap_code_e     trap_code_o
);

  // Offset of the access inside the word
  logic [mem_stage_pkg::LANE_IDX_W-1:0] lane;
  // Address with the lane bits cleared
  logic [mem_stage_pkg::XLEN-1:0]       word_addr;

  // Memory instruction of any kind
  logic                                 is_mem_op;
  // Address does not fit the access size
  logic                                 misalign;
  // Any trap blocks the access
  logic                                 blocked;

  // Store data and strobes before write gating
  logic [mem_stage_pkg::XLEN-1:0]       st_data;
  logic [mem_stage_pkg::NUM_LANES-1:0]  st_strb;

  assign lane      = ex_i.alu_result[mem_stage_pkg::LANE_IDX_W-1:0];
  assign word_addr = {ex_i.alu_result[mem_stage_pkg::XLEN-1:mem_stage_pkg::LANE_IDX_W],
                      {mem_stage_pkg::LANE_IDX_W{1'b0}}};
  assign is_mem_op = ex_i.mem_read | ex_i.mem_write;

  // ====================================================================
  // Misalignment check
  // ====================================================================

  always_comb begin
    misalign = 1'b0;
    if (is_mem_op) begin
      case (ex_i.size)
        // Halfword needs an even address
        mem_stage_pkg::LS_H,
        mem_stage_pkg::LS_HU: misalign = lane[0];
        // Word needs both low bits clear
        mem_stage_pkg::LS_W:  misalign = |lane;
        // Byte is always aligned
        default:              misalign = 1'b0;
      endcase
    end
  end

  // Misalignment overrides the incoming code
  assign trap_o      = ex_i.trap | misalign;
  assign trap_code_o = misalign ? mem_stage_pkg::TRAP_LDST_MISALIGN : ex_i.trap_code;
  assign blocked     = trap_o;

  // ====================================================================
  // Store formatting
  // ====================================================================

  always_comb begin
    case (ex_i.size)
      mem_stage_pkg::LS_B,
      mem_stage_pkg::LS_BU: begin
        // Low byte copied into every lane, one strobe at the offset
        st_data = {mem_stage_pkg::NUM_LANES{ex_i.rs2_data[7:0]}};
        st_strb = {{(mem_stage_pkg::NUM_LANES-1){1'b0}}, 1'b1} << lane;
      end
      mem_stage_pkg::LS_H,
      mem_stage_pkg::LS_HU: begin
        // Low half copied into both halves, upper or lower pair of strobes
        st_data = {2{ex_i.rs2_data[15:0]}};
        st_strb = lane[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        // Full word as is
        st_data = ex_i.rs2_data;
        st_strb = '1;
      end
    endcase
  end

  // ====================================================================
  // Memory request
  // ====================================================================

  // Only valid, untrapped memory instructions touch the memory
  assign dmem_req_o.ren   = ex_valid_i & ex_i.mem_read & ~blocked;
  assign dmem_req_o.raddr = word_addr;
  assign dmem_req_o.we    = ex_valid_i & ex_i.mem_write & ~blocked;
  assign dmem_req_o.waddr = word_addr;
  assign dmem_req_o.wdata = st_data;
  // No strobes for anything but a store
  assign dmem_req_o.wstrb = ex_i.mem_write ? st_strb : '0;

endmodule

// File: hdl/load_align.sv
`timescale 1ns/10ps

// Load data alignment and extension
// Moves the addressed byte or halfword down to bit 0
module load_align (
  input  logic [mem_stage_pkg::XLEN-1:0]       rdata_i,
  input  logic [mem_stage_pkg::LANE_IDX_W-1:0] addr_lo_i,
  input  mem_stage_pkg::ls_size_e              size_i,
  output logic [mem_stage_pkg::XLEN-1:0]       ld_data_o
);

  // Selected byte at the offset
  logic [mem_stage_pkg::BYTE_W-1:0] ld_byte;
  // Selected halfword, upper or lower half of the word
  logic [mem_stage_pkg::HALF_W-1:0] ld_half;

  // ====================================================================
  // Lane select
  // ====================================================================

  always_comb begin
    case (addr_lo_i)
      2'd0:    ld_byte = rdata_i[7:0];
      2'd1:    ld_byte = rdata_i[15:8];
      2'd2:    ld_byte = rdata_i[23:16];
      default: ld_byte = rdata_i[31:24];
    endcase
  end

  // Bit 0 of the offset is zero for an aligned halfword
  assign ld_half = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

  // ====================================================================
  // Extension
  // ====================================================================

  always_comb begin
    case (size_i)
      // Signed byte
      mem_stage_pkg::LS_B:
        ld_data_o = {{(mem_stage_pkg::XLEN-mem_stage_pkg::BYTE_W){ld_byte[7]}}, ld_byte};
      // Unsigned byte
      mem_stage_pkg::LS_BU:
        ld_data_o = {{(mem_stage_pkg::XLEN-mem_stage_pkg::BYTE_W){1'b0}}, ld_byte};
      // Signed halfword
      mem_stage_pkg::LS_H:
        ld_data_o = {{(mem_stage_pkg::XLEN-mem_stage_pkg::HALF_W){ld_half[15]}}, ld_half};
      // Unsigned halfword
      mem_stage_pkg::LS_HU:
        ld_data_o = {{(mem_stage_pkg::XLEN-mem_stage_pkg::HALF_W){1'b0}}, ld_half};
      // Word passes through
      default:
        ld_data_o = rdata_i;
    endcase
  end

endmodule

// File: hdl/mem_wb_reg.sv
`timescale 1ns/10ps

// Writeback value select, forwarding result and MEM/WB register
module mem_wb_reg (
  input  logic                              clk,
  input  logic                              rst_n,

  // Instruction in the memory stage
  input  logic                              ex_valid_i,
  input  mem_stage_pkg::ex_mem_t            ex_i,

  // Merged trap from the access path
  input  logic                              trap_i,
  input  mem_stage_pkg::trap_code_e         trap_code_i,

  // Aligned load data
  input  logic [mem_stage_pkg::XLEN-1:0]    ld_data_i,

  // Hold the register
  input  logic                              stall_i,

  output logic [mem_stage_pkg::XLEN-1:0]    fwd_result_o,
  output logic                              wb_valid_o,
  output mem_stage_pkg::mem_wb_t            wb_o
);

  // Value the instruction will write to rd
  logic [mem_stage_pkg::XLEN-1:0]       result;

  // Register advances whenever the hazard unit lets it
  logic                                 advance;

  // Control part of the register, cleared on reset and bubble
  logic                                 valid_q;
  logic                                 reg_write_q;
  logic                                 trap_q;

  // Payload part of the register
  logic [mem_stage_pkg::REG_ADDR_W-1:0] rd_q;
  logic [mem_stage_pkg::XLEN-1:0]       wb_data_q;
  mem_stage_pkg::trap_code_e            trap_code_q;

  // ====================================================================
  // Result select
  // ====================================================================

  always_comb begin
    case (ex_i.res_src)
      mem_stage_pkg::RES_MEM: result = ld_data_i;
      mem_stage_pkg::RES_PC4: result = ex_i.pc_plus4;
      mem_stage_pkg::RES_TGT: result = ex_i.jb_tgt;
      mem_stage_pkg::RES_CSR: result = ex_i.csr_rdata;
      // ALU ops and anything unknown
      default:                result = ex_i.alu_result;
    endcase
  end

  // Same value goes out for forwarding in this cycle
  assign fwd_result_o = result;

  // ====================================================================
  // MEM/WB register
  // ====================================================================

  assign advance = ~stall_i;

  // Control fields, an empty slot loads as a bubble
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q     <= 1'b0;
      reg_write_q <= 1'b0;
      trap_q      <= 1'b0;
    end else if (advance) begin
      valid_q     <= ex_valid_i;
      // A trapping instruction never writes rd
      reg_write_q <= ex_valid_i & ex_i.reg_write & ~trap_i;
      trap_q      <= ex_valid_i & trap_i;
    end
  end

  // Payload, left as is on a bubble
  always_ff @(posedge clk) begin
    if (advance && ex_valid_i) begin
      rd_q        <= ex_i.rd;
      wb_data_q   <= result;
      trap_code_q <= trap_code_i;
    end
  end

  assign wb_valid_o = valid_q;
  assign wb_o = '{
    reg_write: reg_write_q,
    rd:        rd_q,
    wb_data:   wb_data_q,
    trap:      trap_q,
    trap_code: trap_code_q
  };

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/10ps

// Data-memory stage of the pipeline
// Access path and load aligner run side by side in the same cycle,
// the writeback select and MEM/WB register combine their results
module mem_stage (
  input  logic                              clk,
  input  logic                              rst_n,

  // From the execute stage
  input  logic                              ex_valid_i,
  input  mem_stage_pkg::ex_mem_t            ex_i,

  // Hazard unit hold
  input  logic                              stall_i,

  // Data memory, read data answers in the same cycle
  output mem_stage_pkg::dmem_req_t          dmem_req_o,
  input  logic [mem_stage_pkg::XLEN-1:0]    dmem_rdata_i,

  // Result for forwarding, valid in the current cycle
  output logic [mem_stage_pkg::XLEN-1:0]    fwd_result_o,

  // Toward writeback
  output logic                              wb_valid_o,
  output mem_stage_pkg::mem_wb_t            wb_o
);

  // ====================================================================
  // Internal wires
  // ====================================================================

  // Combined trap (incoming or misaligned) and its final code
  logic                                mem_trap;
  mem_stage_pkg::trap_code_e           mem_trap_code;

  // Load data after lane select and extension
  logic [mem_stage_pkg::XLEN-1:0]      ld_data;

  // ====================================================================
  // Memory access path
  // ====================================================================

  mem_access i_mem_access (
    .ex_valid_i  (ex_valid_i),
    .ex_i        (ex_i),
    .dmem_req_o  (dmem_req_o),
    .trap_o      (mem_trap),
    .trap_code_o (mem_trap_code)
  );

  // ====================================================================
  // Load aligner
  // ====================================================================

  // Byte offset inside the word comes straight from the address
  load_align i_load_align (
    .rdata_i   (dmem_rdata_i),
    .addr_lo_i (ex_i.alu_result[mem_stage_pkg::LANE_IDX_W-1:0]),
    .size_i    (ex_i.size),
    .ld_data_o (ld_data)
  );

  // ====================================================================
  // Writeback select and MEM/WB register
  // ====================================================================

  mem_wb_reg i_mem_wb_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_i   (ex_valid_i),
    .ex_i         (ex_i),
    .trap_i       (mem_trap),
    .trap_code_i  (mem_trap_code),
    .ld_data_i    (ld_data),
    .stall_i      (stall_i),
    .fwd_result_o (fwd_result_o),
    .wb_valid_o   (wb_valid_o),
    .wb_o         (wb_o)
  );

endmodule

// File: test/mem_stage_properties.sv
`timescale 1ns/10ps

// Boundary checks on the memory stage
module mem_stage_properties (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     ex_valid_i,
  input logic                     stall_i,
  input mem_stage_pkg::dmem_req_t dmem_req_i,
  input logic                     wb_valid_i,
  input mem_stage_pkg::mem_wb_t   wb_i
);

  // ====================================================================
  // Memory request
  // ====================================================================

  // No read or write without a valid instruction
  no_access_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    !ex_valid_i |-> !dmem_req_i.ren && !dmem_req_i.we
  ) else $error("Memory request active while ex_valid_i is low");

  // ====================================================================
  // MEM/WB register
  // ====================================================================

  // Held content does not move across a stalled edge
  hold_under_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    stall_i && wb_valid_i |=> $stable(wb_i) && $stable(wb_valid_i)
  ) else $error("MEM/WB register changed during a stall");

  // A trapping instruction never writes rd
  no_write_on_trap: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(wb_i.reg_write && wb_i.trap)
  ) else $error("Register write raised together with a trap");

endmodule

bind mem_stage mem_stage_properties i_mem_stage_properties (
  .clk        (clk),
  .rst_n      (rst_n),
  .ex_valid_i (ex_valid_i),
  .stall_i    (stall_i),
  .dmem_req_i (dmem_req_o),
  .wb_valid_i (wb_valid_o),
  .wb_i       (wb_o)
);

// File: test/mem_stage_tb.sv
`timescale 1ns/10ps

module mem_stage_tb;

  // ====================================================================
  // Table layout and timing
  // ====================================================================

  // One cycle of stimulus with everything expected from it
  typedef struct packed {
    logic                           ex_valid;
    logic                           stall;
    mem_stage_pkg::ex_mem_t         ex;
    mem_stage_pkg::dmem_req_t       exp_req;
    logic                           chk_result;  // Result is defined for this row
    logic [mem_stage_pkg::XLEN-1:0] exp_result;
    mem_stage_pkg::mem_wb_t         exp_wb;
  } row_t;

  localparam int MEM_WORDS    = 64;
  localparam int CLK_HALF     = 20;
  localparam int RESET_CYCLES = 4;
  // Inputs change just after the edge, outputs are sampled late in the cycle
  localparam int DRIVE_DELAY  = 1;
  localparam int SAMPLE_DELAY = 28;

  logic                           clk;
  logic                           rst_n;
  logic                           ex_valid_i;
  mem_stage_pkg::ex_mem_t         ex_i;
  logic                           stall_i;
  mem_stage_pkg::dmem_req_t       dmem_req_o;
  logic [mem_stage_pkg::XLEN-1:0] dmem_rdata_i;
  logic [mem_stage_pkg::XLEN-1:0] fwd_result_o;
  logic                           wb_valid_o;
  mem_stage_pkg::mem_wb_t         wb_o;

  // Data memory seen by the DUT, and the contents the rules predict
  logic [31:0] mem     [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];

  row_t rows [$];
  row_t cur_row;

  // Predicted MEM/WB register
  logic                   exp_wb_valid;
  mem_stage_pkg::mem_wb_t exp_wb;
  logic                   exp_wb_chk_data;

  int err_cnt;
  int cycle_cnt;
  int timeout_cycles;

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  mem_stage i_mem_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_i   (ex_valid_i),
    .ex_i         (ex_i),
    .stall_i      (stall_i),
    .dmem_req_o   (dmem_req_o),
    .dmem_rdata_i (dmem_rdata_i),
    .fwd_result_o (fwd_result_o),
    .wb_valid_o   (wb_valid_o),
    .wb_o         (wb_o)
  );

  // ====================================================================
  // Memory model
  // ====================================================================

  // Same-cycle read, word index from address bits 7:2
  assign dmem_rdata_i = mem[dmem_req_o.raddr[7:2]];

  // Strobed write at the edge
  always @(posedge clk) begin
    if (dmem_req_o.we) begin
      for (int l = 0; l < 4; l++) begin
        if (dmem_req_o.wstrb[l]) begin
          mem[dmem_req_o.waddr[7:2]][8*l +: 8] <= dmem_req_o.wdata[8*l +: 8];
        end
      end
    end
  end

  // ====================================================================
  // Reference rules
  // ====================================================================

  // Access must sit on a multiple of its own size
  function automatic logic is_misaligned(input mem_stage_pkg::ls_size_e size,
                                         input logic [31:0] addr);
    logic [31:0] bytes;
    bytes = 32'd1 << size[1:0];
    return (addr % bytes) != 32'd0;
  endfunction

  // Shift the addressed data down, then extend by the size code
  function automatic logic [31:0] load_value(input mem_stage_pkg::ls_size_e size,
                                             input logic [31:0] addr);
    logic [31:0] word;
    logic [31:0] shifted;
    word    = ref_mem[addr[7:2]];
    shifted = word >> (8 * addr[1:0]);
    case (size)
      mem_stage_pkg::LS_B:  return (shifted[7] ? 32'hffffff00 : 32'h0) | (shifted & 32'hff);
      mem_stage_pkg::LS_BU: return shifted & 32'hff;
      mem_stage_pkg::LS_H:  return (shifted[15] ? 32'hffff0000 : 32'h0) | (shifted & 32'hffff);
      mem_stage_pkg::LS_HU: return shifted & 32'hffff;
      default:              return word;
    endcase
  endfunction

  // Plain ALU instruction with random side values
  function automatic mem_stage_pkg::ex_mem_t base_ex();
    mem_stage_pkg::ex_mem_t ex;
    ex            = '0;
    ex.res_src    = mem_stage_pkg::RES_ALU;
    ex.size       = mem_stage_pkg::LS_W;
    ex.trap_code  = mem_stage_pkg::TRAP_NONE;
    ex.alu_result = $urandom;
    ex.rs2_data   = $urandom;
    ex.pc_plus4   = $urandom;
    ex.jb_tgt     = $urandom;
    ex.csr_rdata  = $urandom;
    return ex;
  endfunction

  // Work out request, result and writeback for one row, then queue it
  task automatic push_row(input logic valid, input logic stall,
                          input mem_stage_pkg::ex_mem_t ex);
    row_t r;
    logic mis;
    logic trap;
    r          = '0;
    r.ex_valid = valid;
    r.stall    = stall;
    r.ex       = ex;
    mis  = (ex.mem_read || ex.mem_write) && is_misaligned(ex.size, ex.alu_result);
    trap = ex.trap || mis;
    r.exp_req.ren   = valid && ex.mem_read && !trap;
    r.exp_req.we    = valid && ex.mem_write && !trap;
    r.exp_req.raddr = ex.alu_result & ~32'h3;
    r.exp_req.waddr = ex.alu_result & ~32'h3;
    if (ex.mem_write) begin
      case (ex.size[1:0])
        2'd0: begin
          r.exp_req.wdata = ex.rs2_data[7:0] * 32'h01010101;
          r.exp_req.wstrb = 4'b0001 << ex.alu_result[1:0];
        end
        2'd1: begin
          r.exp_req.wdata = ex.rs2_data[15:0] * 32'h00010001;
          r.exp_req.wstrb = 4'b0011 << ex.alu_result[1:0];
        end
        default: begin
          r.exp_req.wdata = ex.rs2_data;
          r.exp_req.wstrb = 4'b1111;
        end
      endcase
    end
    r.chk_result = valid && !trap;
    case (ex.res_src)
      mem_stage_pkg::RES_MEM: r.exp_result = load_value(ex.size, ex.alu_result);
      mem_stage_pkg::RES_PC4: r.exp_result = ex.pc_plus4;
      mem_stage_pkg::RES_TGT: r.exp_result = ex.jb_tgt;
      mem_stage_pkg::RES_CSR: r.exp_result = ex.csr_rdata;
      default:                r.exp_result = ex.alu_result;
    endcase
    // Later loads see this store
    if (r.exp_req.we) begin
      for (int l = 0; l < 4; l++) begin
        if (r.exp_req.wstrb[l]) begin
          ref_mem[ex.alu_result[7:2]][8*l +: 8] = r.exp_req.wdata[8*l +: 8];
        end
      end
    end
    r.exp_wb.reg_write = ex.reg_write && !trap;
    r.exp_wb.rd        = ex.rd;
    r.exp_wb.wb_data   = r.exp_result;
    r.exp_wb.trap      = trap;
    r.exp_wb.trap_code = mis ? mem_stage_pkg::TRAP_LDST_MISALIGN : ex.trap_code;
    rows.push_back(r);
  endtask

  task automatic add_store(input mem_stage_pkg::ls_size_e size, input logic [31:0] addr,
                           input logic [31:0] data);
    mem_stage_pkg::ex_mem_t ex;
    ex            = base_ex();
    ex.mem_write  = 1'b1;
    ex.size       = size;
    ex.alu_result = addr;
    ex.rs2_data   = data;
    push_row(1'b1, 1'b0, ex);
  endtask

  task automatic add_load(input mem_stage_pkg::ls_size_e size, input logic [31:0] addr,
                          input logic [4:0] rd);
    mem_stage_pkg::ex_mem_t ex;
    ex            = base_ex();
    ex.mem_read   = 1'b1;
    ex.reg_write  = 1'b1;
    ex.res_src    = mem_stage_pkg::RES_MEM;
    ex.size       = size;
    ex.alu_result = addr;
    ex.rd         = rd;
    push_row(1'b1, 1'b0, ex);
  endtask

  task automatic add_op(input mem_stage_pkg::res_src_e src, input logic [4:0] rd,
                        input logic stall);
    mem_stage_pkg::ex_mem_t ex;
    ex           = base_ex();
    ex.reg_write = 1'b1;
    ex.res_src   = src;
    ex.rd        = rd;
    push_row(1'b1, stall, ex);
  endtask

  // Aligned load that already carries a trap from upstream
  task automatic add_trap_in(input mem_stage_pkg::trap_code_e code, input logic [4:0] rd);
    mem_stage_pkg::ex_mem_t ex;
    ex            = base_ex();
    ex.mem_read   = 1'b1;
    ex.reg_write  = 1'b1;
    ex.res_src    = mem_stage_pkg::RES_MEM;
    ex.alu_result = 32'h48;
    ex.rd         = rd;
    ex.trap       = 1'b1;
    ex.trap_code  = code;
    push_row(1'b1, 1'b0, ex);
  endtask

  task automatic build_table();
    mem_stage_pkg::ex_mem_t held;
    mem_stage_pkg::ex_mem_t idle_mem;
    // Byte stores at all four offsets, then read back the merged word
    for (int off = 0; off < 4; off++) begin
      add_store(mem_stage_pkg::LS_B, 32'h40 + off, $urandom);
    end
    add_load(mem_stage_pkg::LS_W, 32'h40, 5'd1);
    add_store(mem_stage_pkg::LS_H, 32'h80, $urandom);
    add_store(mem_stage_pkg::LS_H, 32'h82, $urandom);
    add_load(mem_stage_pkg::LS_W, 32'h80, 5'd2);
    add_store(mem_stage_pkg::LS_W, 32'h90, $urandom);
    add_load(mem_stage_pkg::LS_W, 32'h90, 5'd3);
    // Known word with both sign polarities in its bytes and halves
    add_store(mem_stage_pkg::LS_W, 32'hc0, 32'h80ff_7f01);
    for (int w = 0; w < 2; w++) begin
      for (int off = 0; off < 4; off++) begin
        add_load(mem_stage_pkg::LS_B, 32'hc0 + 4 * w + off, 5'(off + 8));
        add_load(mem_stage_pkg::LS_BU, 32'hc0 + 4 * w + off, 5'(off + 12));
      end
      for (int off = 0; off < 4; off += 2) begin
        add_load(mem_stage_pkg::LS_H, 32'hc0 + 4 * w + off, 5'(off + 16));
        add_load(mem_stage_pkg::LS_HU, 32'hc0 + 4 * w + off, 5'(off + 20));
      end
      add_load(mem_stage_pkg::LS_W, 32'hc0 + 4 * w, 5'd24);
    end
    // Misaligned accesses
    // Blocked stores leave the word at 0x44 untouched
    add_load(mem_stage_pkg::LS_H, 32'h41, 5'd4);
    add_load(mem_stage_pkg::LS_HU, 32'h43, 5'd5);
    add_load(mem_stage_pkg::LS_W, 32'h42, 5'd6);
    add_store(mem_stage_pkg::LS_H, 32'h45, $urandom);
    add_store(mem_stage_pkg::LS_W, 32'h47, $urandom);
    add_load(mem_stage_pkg::LS_W, 32'h44, 5'd7);
    add_trap_in(mem_stage_pkg::TRAP_ILLEGAL, 5'd25);
    add_trap_in(mem_stage_pkg::TRAP_ECALL, 5'd26);
    // Result sources
    add_op(mem_stage_pkg::RES_PC4, 5'd27, 1'b0);
    add_op(mem_stage_pkg::RES_TGT, 5'd28, 1'b0);
    add_op(mem_stage_pkg::RES_CSR, 5'd29, 1'b0);
    add_op(mem_stage_pkg::RES_ALU, 5'd30, 1'b0);
    // Two stalled cycles, then the held instruction goes through
    held           = base_ex();
    held.reg_write = 1'b1;
    held.res_src   = mem_stage_pkg::RES_CSR;
    held.rd        = 5'd31;
    push_row(1'b1, 1'b1, held);
    push_row(1'b1, 1'b1, held);
    push_row(1'b1, 1'b0, held);
    // Bubble carrying a store to the word read back below
    idle_mem            = base_ex();
    idle_mem.mem_write  = 1'b1;
    idle_mem.alu_result = 32'h80;
    push_row(1'b0, 1'b0, idle_mem);
    // Stall over the bubble, then a load
    add_op(mem_stage_pkg::RES_ALU, 5'd9, 1'b1);
    add_load(mem_stage_pkg::LS_HU, 32'h82, 5'd10);
    // Bubble carrying a load
    idle_mem            = base_ex();
    idle_mem.mem_read   = 1'b1;
    idle_mem.reg_write  = 1'b1;
    idle_mem.res_src    = mem_stage_pkg::RES_MEM;
    idle_mem.alu_result = 32'h40;
    push_row(1'b0, 1'b0, idle_mem);
  endtask

  // ====================================================================
  // Drive and check
  // ====================================================================

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    err_cnt++;
    $display("Fail at time %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
  endtask

  task automatic drive_row(input row_t r);
    cur_row    = r;
    ex_valid_i = r.ex_valid;
    stall_i    = r.stall;
    ex_i       = r.ex;
  endtask

  // Advance the predicted MEM/WB register over one edge
  task automatic update_wb_model();
    if (!cur_row.stall) begin
      if (cur_row.ex_valid) begin
        exp_wb_valid    = 1'b1;
        exp_wb          = cur_row.exp_wb;
        exp_wb_chk_data = cur_row.chk_result;
      end else begin
        exp_wb_valid     = 1'b0;
        exp_wb.reg_write = 1'b0;
        exp_wb.trap      = 1'b0;
      end
    end
  endtask

  task automatic check_request_and_result();
    row_t r;
    r = cur_row;
    if (dmem_req_o.ren !== r.exp_req.ren)
      report_mismatch("dmem_req_o.ren", 32'(r.exp_req.ren), 32'(dmem_req_o.ren));
    if (dmem_req_o.we !== r.exp_req.we)
      report_mismatch("dmem_req_o.we", 32'(r.exp_req.we), 32'(dmem_req_o.we));
    if (r.exp_req.ren && dmem_req_o.raddr !== r.exp_req.raddr)
      report_mismatch("dmem_req_o.raddr", r.exp_req.raddr, dmem_req_o.raddr);
    if (r.exp_req.we && dmem_req_o.waddr !== r.exp_req.waddr)
      report_mismatch("dmem_req_o.waddr", r.exp_req.waddr, dmem_req_o.waddr);
    if (r.exp_req.we && dmem_req_o.wdata !== r.exp_req.wdata)
      report_mismatch("dmem_req_o.wdata", r.exp_req.wdata, dmem_req_o.wdata);
    // Strobes of a trapped store are left open
    if (!(r.ex.mem_write && r.exp_wb.trap) && dmem_req_o.wstrb !== r.exp_req.wstrb)
      report_mismatch("dmem_req_o.wstrb", 32'(r.exp_req.wstrb), 32'(dmem_req_o.wstrb));
    if (r.chk_result && fwd_result_o !== r.exp_result)
      report_mismatch("fwd_result_o", r.exp_result, fwd_result_o);
  endtask

  task automatic check_writeback();
    if (wb_valid_o !== exp_wb_valid)
      report_mismatch("wb_valid_o", 32'(exp_wb_valid), 32'(wb_valid_o));
    if (wb_o.reg_write !== exp_wb.reg_write)
      report_mismatch("wb_o.reg_write", 32'(exp_wb.reg_write), 32'(wb_o.reg_write));
    if (wb_o.trap !== exp_wb.trap)
      report_mismatch("wb_o.trap", 32'(exp_wb.trap), 32'(wb_o.trap));
    if (exp_wb_valid && wb_o.rd !== exp_wb.rd)
      report_mismatch("wb_o.rd", 32'(exp_wb.rd), 32'(wb_o.rd));
    if (exp_wb_valid && wb_o.trap_code !== exp_wb.trap_code)
      report_mismatch("wb_o.trap_code", 32'(exp_wb.trap_code), 32'(wb_o.trap_code));
    if (exp_wb_valid && exp_wb_chk_data && wb_o.wb_data !== exp_wb.wb_data)
      report_mismatch("wb_o.wb_data", exp_wb.wb_data, wb_o.wb_data);
  endtask

  initial begin : stimulus
    row_t idle;
    rst_n      = 1'b0;
    ex_valid_i = 1'b0;
    stall_i    = 1'b0;
    ex_i       = '0;
    err_cnt    = 0;
    void'($urandom(32'hf18427b7));
    for (int w = 0; w < MEM_WORDS; w++) begin
      mem[w]     = $urandom;
      ref_mem[w] = mem[w];
    end
    build_table();
    timeout_cycles  = rows.size() + 20;
    idle            = '0;
    cur_row         = idle;
    exp_wb_valid    = 1'b0;
    exp_wb          = '0;
    exp_wb_chk_data = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY rst_n = 1'b1;
    // Control fields right after reset
    #SAMPLE_DELAY check_writeback();
    foreach (rows[i]) begin
      @(posedge clk);
      update_wb_model();
      #DRIVE_DELAY drive_row(rows[i]);
      #SAMPLE_DELAY;
      check_request_and_result();
      check_writeback();
    end
    // Drain the last instruction, then one bubble
    repeat (2) begin
      @(posedge clk);
      update_wb_model();
      #DRIVE_DELAY drive_row(idle);
      #SAMPLE_DELAY check_writeback();
    end
    $display("Rows applied: %0d, errors: %0d", rows.size(), err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Cycle limit from the table length
  initial begin : watchdog
    @(posedge clk);
    cycle_cnt = 1;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, stimulus loop did not finish", cycle_cnt);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: tb.f
hdl/mem_stage_pkg.sv
hdl/mem_access.sv
hdl/load_align.sv
hdl/mem_wb_reg.sv
hdl/mem_stage.sv
test/mem_stage_properties.sv
test/mem_stage_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module mem_stage_tb -f tb.f -o Vmem_stage_tb

# The verdict comes from the simulation output
sim_out=$(./obj_dir/Vmem_stage_tb 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TEST PASSED"; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1
